/* compile.f */
src/mpu_pkg.sv
src/pma_check.sv
src/pmp_check.sv
src/txn_tracker.sv
src/mpu.sv
src/mpu_top.sv
testbench/mpu_assert.sv
testbench/tb_mpu.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the MPU testbench with Verilator, run it and judge the log
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
  --top-module tb_mpu -f compile.f -o tb_mpu_sim \
  && ./obj_dir/tb_mpu_sim | tee sim.log \
  || { echo "Build or simulation run failed"; exit 1; }
grep -q "STATUS: FAIL" sim.log && { echo "Simulation reported failure"; exit 1; }
grep -q "STATUS: PASS" sim.log || { echo "No pass result in log"; exit 1; }
echo "Simulation passed"

/* testbench/tb_mpu.sv */
/*
  MPU testbench
  Random core requests against a bus memory responder, checked by a reference model
*/
module tb_mpu;

  timeunit 1ns;
  timeprecision 100ps;

  import mpu_pkg::*;

  localparam int unsigned N_REQ       = 600;
  localparam int unsigned PHASE_LEN   = 200;
  localparam int unsigned CYCLE_LIMIT = N_REQ * 8;
  localparam int unsigned PMP_N       = 4;

  // Region 1 main memory with all attributes, region 0 the IO window
  localparam pma_region_t [1:0] PMA_CFG = {
    pma_region_t'{32'h0000_0000, 32'hF000_0000, 1'b1, 1'b1, 1'b1},
    pma_region_t'{32'h1000_0000, 32'hF000_0000, 1'b0, 1'b1, 1'b0}
  };

  // Address windows: PMP regions 0 to 3, then nothing matched
  localparam logic [ADDR_W-1:0] WINDOWS [5] = '{
    32'h0000_0000, 32'h0000_1000, 32'h1000_0000, 32'h2000_0000, 32'h3000_0000
  };

  // Per phase r/w/lock bits, phase 0 has no locks
  localparam logic [7:0] PMP_R [3] = '{8'h0F, 8'h0B, 8'h07};
  localparam logic [7:0] PMP_W [3] = '{8'h0D, 8'h05, 8'h0B};
  localparam logic [7:0] PMP_L [3] = '{8'h00, 8'h06, 8'h09};

  logic                                   clk;
  logic                                   rst_n;
  logic                                   core_trans_valid_i;
  logic                                   core_trans_ready_o;
  logic [ADDR_W-1:0]                      core_addr_i;
  logic                                   core_we_i;
  logic [DATA_W-1:0]                      core_wdata_i;
  logic                                   core_misaligned_i;
  logic                                   core_resp_valid_o;
  logic [DATA_W-1:0]                      core_rdata_o;
  mpu_status_e                            core_status_o;
  logic                                   bus_trans_valid_o;
  logic                                   bus_trans_ready_i;
  logic [ADDR_W-1:0]                      bus_addr_o;
  logic                                   bus_we_o;
  logic [DATA_W-1:0]                      bus_wdata_o;
  logic                                   bus_bufferable_o;
  logic                                   bus_cacheable_o;
  logic                                   bus_resp_valid_i;
  logic [DATA_W-1:0]                      bus_rdata_i;
  logic [MAX_PMP_REGIONS-1:0][ADDR_W-1:0] pmp_top_i;
  logic [MAX_PMP_REGIONS-1:0]             pmp_r_i;
  logic [MAX_PMP_REGIONS-1:0]             pmp_w_i;
  logic [MAX_PMP_REGIONS-1:0]             pmp_l_i;
  priv_lvl_e                              priv_lvl_i;
  logic                                   core_mpu_err_o;

  logic [31:0]       seed;
  logic              req_live;
  int unsigned       cycle;
  int unsigned       wd_cycles;
  int unsigned       n_acc;
  int unsigned       n_resp;
  int unsigned       checks;
  int unsigned       errors;
  // Bus memory and the model's own copy
  logic [DATA_W-1:0] bus_mem [256];
  logic [DATA_W-1:0] model_mem [256];
  // Accepted bus requests in order, with read data and answer cycle
  logic [DATA_W-1:0] bus_rd_q [$];
  int unsigned       bus_due_q [$];
  // Expected core responses in acceptance order
  mpu_status_e       exp_status_q [$];
  logic [DATA_W-1:0] exp_rdata_q [$];

  mpu_top #(
    .PMA_NUM_REGIONS (2),
    .PMA_CFG         (PMA_CFG),
    .PMP_NUM_REGIONS (PMP_N),
    .CNT_W           (3)
  ) i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers and reference model
  ////////////////////////////////////////////////////////////////////////////

  // LCG, upper bits used
  function automatic int unsigned rand_below(input int unsigned n);
    seed = seed * 32'd1664525 + 32'd1013904223;
    return (seed >> 16) % n;
  endfunction

  function automatic logic [DATA_W-1:0] fill_word(input int unsigned idx);
    return 32'hA5C3_0000 ^ (idx * 32'h0001_0101) ^ (idx << 20);
  endfunction

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("ERROR @%0t: %s is %0h, expected %0h", $time, what, actual, expected);
    end
  endtask

  // {main, bufferable, cacheable} from the address map
  function automatic logic [2:0] pma_attr(input logic [ADDR_W-1:0] addr);
    case (addr[31:28])
      4'h0:    return 3'b111;
      4'h1:    return 3'b010;
      default: return 3'b100;
    endcase
  endfunction

  function automatic logic pmp_denied(input logic [ADDR_W-1:0] addr, input logic we,
                                      input priv_lvl_e priv);
    logic [ADDR_W-1:0] lo;
    lo = '0;
    for (int i = 0; i < PMP_N; i++) begin
      if (addr >= lo && addr < pmp_top_i[i]) begin
        // Unlocked regions do not bind M-mode
        if (priv == PRIV_M && !pmp_l_i[i]) begin
          return 1'b0;
        end
        return we ? !pmp_w_i[i] : !pmp_r_i[i];
      end
      lo = pmp_top_i[i];
    end
    // No region hit, only M-mode gets through
    return priv != PRIV_M;
  endfunction

  function automatic logic exp_fault(input logic [ADDR_W-1:0] addr, input logic we,
                                     input logic mis, input priv_lvl_e priv);
    logic [2:0] attr;
    attr = pma_attr(addr);
    return (mis && !attr[2]) || pmp_denied(addr, we, priv);
  endfunction

  task automatic set_pmp(input int unsigned phase);
    pmp_top_i    = '0;
    pmp_top_i[0] = 32'h0000_1000;
    pmp_top_i[1] = 32'h0000_2000;
    pmp_top_i[2] = 32'h1000_1000;
    pmp_top_i[3] = 32'h2000_1000;
    pmp_r_i      = PMP_R[phase];
    pmp_w_i      = PMP_W[phase];
    pmp_l_i      = PMP_L[phase];
  endtask

  task automatic new_request();
    core_addr_i       = WINDOWS[rand_below(5)] | {22'h0, 8'(rand_below(256)), 2'b00};
    core_we_i         = (rand_below(2) == 1);
    core_wdata_i      = {16'(rand_below(65536)), 16'(rand_below(65536))};
    core_misaligned_i = (rand_below(6) == 0);
    core_addr_i[1]    = core_misaligned_i;
    priv_lvl_i        = (rand_below(2) == 0) ? PRIV_U : PRIV_M;
    req_live          = 1'b1;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Per cycle drive and sample
  ////////////////////////////////////////////////////////////////////////////

  task automatic drive_inputs();
    // Head of the bus queue answers once due
    bus_resp_valid_i = 1'b0;
    bus_rdata_i      = '0;
    if (bus_due_q.size() > 0 && bus_due_q[0] <= cycle) begin
      bus_resp_valid_i = 1'b1;
      bus_rdata_i      = bus_rd_q[0];
    end
    bus_trans_ready_i = (rand_below(4) != 0);
    if (!req_live && n_acc < N_REQ && rand_below(4) != 0) begin
      // New PMP setup at each phase start
      if (n_acc % PHASE_LEN == 0) begin
        set_pmp(n_acc / PHASE_LEN);
      end
      new_request();
    end
    core_trans_valid_i = req_live;
  endtask

  task automatic sample_outputs();
    logic [2:0]  attr;
    logic        fault;
    mpu_status_e st;
    if (bus_resp_valid_i) begin
      void'(bus_rd_q.pop_front());
      void'(bus_due_q.pop_front());
    end
    if (bus_trans_valid_o) begin
      attr = pma_attr(core_addr_i);
      check_value(32'({bus_bufferable_o, bus_cacheable_o}), 32'(attr[1:0]), "bus attributes");
      check_value(bus_addr_o, core_addr_i, "bus address");
      check_value(32'(bus_we_o), 32'(core_we_i), "bus write enable");
      check_value(bus_wdata_o, core_wdata_i, "bus write data");
      check_value(32'(exp_fault(core_addr_i, core_we_i, core_misaligned_i, priv_lvl_i)),
                  32'd0, "faulting request on the bus");
    end
    if (bus_trans_valid_o && bus_trans_ready_i) begin
      if (bus_we_o) begin
        bus_mem[bus_addr_o[9:2]] = bus_wdata_o;
      end
      bus_rd_q.push_back(bus_we_o ? '0 : bus_mem[bus_addr_o[9:2]]);
      bus_due_q.push_back(cycle + 1 + rand_below(4));
    end
    if (core_resp_valid_o) begin
      n_resp++;
      if (exp_status_q.size() == 0) begin
        errors++;
        $display("Unexpected core response at %0t with nothing outstanding", $time);
      end else begin
        check_value(32'(core_status_o), 32'(exp_status_q.pop_front()), "response status");
        check_value(core_rdata_o, exp_rdata_q.pop_front(), "response data");
      end
    end
    if (core_trans_valid_i && core_trans_ready_o) begin
      fault = exp_fault(core_addr_i, core_we_i, core_misaligned_i, priv_lvl_i);
      check_value(32'(core_mpu_err_o), 32'(fault), "mpu error flag");
      // Pass goes to the bus in the same cycle, fault never does
      check_value(32'(bus_trans_valid_o && bus_trans_ready_i), 32'(!fault), "bus handoff");
      st = !fault ? MPU_OK : (core_we_i ? MPU_WR_FAULT : MPU_RE_FAULT);
      exp_status_q.push_back(st);
      exp_rdata_q.push_back((fault || core_we_i) ? '0 : model_mem[core_addr_i[9:2]]);
      if (!fault && core_we_i) begin
        model_mem[core_addr_i[9:2]] = core_wdata_i;
      end
      n_acc++;
      req_live = 1'b0;
    end
  endtask

  task automatic run_cycle();
    @(negedge clk);
    cycle++;
    drive_inputs();
    // Outputs settled well before the next rising edge
    #2;
    sample_outputs();
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    seed               = 32'd85;
    req_live           = 1'b0;
    cycle              = 0;
    n_acc              = 0;
    n_resp             = 0;
    checks             = 0;
    errors             = 0;
    rst_n              = 1'b0;
    core_trans_valid_i = 1'b0;
    core_addr_i        = '0;
    core_we_i          = 1'b0;
    core_wdata_i       = '0;
    core_misaligned_i  = 1'b0;
    bus_trans_ready_i  = 1'b0;
    bus_resp_valid_i   = 1'b0;
    bus_rdata_i        = '0;
    priv_lvl_i         = PRIV_M;
    set_pmp(0);
    for (int i = 0; i < 256; i++) begin
      bus_mem[i]   = fill_word(i);
      model_mem[i] = fill_word(i);
    end
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    while (n_acc < N_REQ || exp_status_q.size() > 0) begin
      run_cycle();
    end
    // Quiet tail catches stray or duplicated responses
    repeat (8) run_cycle();
    check_value(n_resp, n_acc, "response count");
    $display("Requests %0d, responses %0d, checks %0d, errors %0d",
             n_acc, n_resp, checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  initial begin
    wd_cycles = 0;
    while (wd_cycles < CYCLE_LIMIT) begin
      @(posedge clk);
      wd_cycles++;
    end
    $display("Timeout after %0d cycles with %0d of %0d requests accepted",
             wd_cycles, n_acc, N_REQ);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

/* testbench/mpu_assert.sv */
/*
  MPU assertions
  Bus blocking, fault and bus response overlap, FSM state in reset
*/
module mpu_assert (
  input logic                clk,
  input logic                rst_n,
  input mpu_pkg::mpu_state_e state_i,
  input logic                bus_valid_i,
  input logic                bus_resp_i,
  input logic                err_valid_i
);

  timeunit 1ns;
  timeprecision 100ps;

  import mpu_pkg::*;

  // Bus request only leaves from IDLE
  bus_only_idle: assert property (@(posedge clk) disable iff (!rst_n)
    bus_valid_i |-> state_i == MPU_IDLE)
    else $error("Bus request issued while the FSM is not idle");

  // Fault response only after bus traffic has drained
  no_resp_overlap: assert property (@(posedge clk) disable iff (!rst_n)
    !(err_valid_i && bus_resp_i))
    else $error("Fault response issued together with a bus response");

  idle_in_reset: assert property (@(posedge clk) !rst_n |-> state_i == MPU_IDLE)
    else $error("FSM not idle during reset");

endmodule

bind mpu mpu_assert i_mpu_assert (
  .clk         (clk),
  .rst_n       (rst_n),
  .state_i     (state_q),
  .bus_valid_i (bus_trans_valid_o),
  .bus_resp_i  (bus_resp_valid_i),
  .err_valid_i (err_valid)
);

/* src/mpu_top.sv */
/*
  MPU top level
  Joins the MPU with its outstanding transaction tracker
*/
module mpu_top #(
  parameter int unsigned PMA_NUM_REGIONS = 1,
  parameter mpu_pkg::pma_region_t [PMA_NUM_REGIONS-1:0] PMA_CFG =
    {PMA_NUM_REGIONS{mpu_pkg::PMA_R_DEFAULT}},
  parameter int unsigned PMP_NUM_REGIONS = 4,
  parameter int unsigned CNT_W           = 3
) (
  input  logic                                                    clk,
  input  logic                                                    rst_n,
  input  logic                                                    core_trans_valid_i,
  output logic                                                    core_trans_ready_o,
  input  logic [mpu_pkg::ADDR_W-1:0]                              core_addr_i,
  input  logic                                                    core_we_i,
  input  logic [mpu_pkg::DATA_W-1:0]                              core_wdata_i,
  input  logic                                                    core_misaligned_i,
  output logic                                                    core_resp_valid_o,
  output logic [mpu_pkg::DATA_W-1:0]                              core_rdata_o,
  output mpu_pkg::mpu_status_e                                    core_status_o,
  output logic                                                    bus_trans_valid_o,
  input  logic                                                    bus_trans_ready_i,
  output logic [mpu_pkg::ADDR_W-1:0]                              bus_addr_o,
  output logic                                                    bus_we_o,
  output logic [mpu_pkg::DATA_W-1:0]                              bus_wdata_o,
  output logic                                                    bus_bufferable_o,
  output logic                                                    bus_cacheable_o,
  input  logic                                                    bus_resp_valid_i,
  input  logic [mpu_pkg::DATA_W-1:0]                              bus_rdata_i,
  input  logic [mpu_pkg::MAX_PMP_REGIONS-1:0][mpu_pkg::ADDR_W-1:0] pmp_top_i,
  input  logic [mpu_pkg::MAX_PMP_REGIONS-1:0]                     pmp_r_i,
  input  logic [mpu_pkg::MAX_PMP_REGIONS-1:0]                     pmp_w_i,
  input  logic [mpu_pkg::MAX_PMP_REGIONS-1:0]                     pmp_l_i,
  input  mpu_pkg::priv_lvl_e                                      priv_lvl_i,
  output logic                                                    core_mpu_err_o
);

  logic one_txn_pend;
  logic core_accept;

  // Core-side handshake feeds the tracker
  assign core_accept = core_trans_valid_i && core_trans_ready_o;

  txn_tracker #(
    .CNT_W (CNT_W)
  ) i_txn_tracker (
    .clk            (clk),
    .rst_n          (rst_n),
    .accept_i       (core_accept),
    .resp_i         (core_resp_valid_o),
    .one_txn_pend_o (one_txn_pend)
  );

  mpu #(
    .PMA_NUM_REGIONS (PMA_NUM_REGIONS),
    .PMA_CFG         (PMA_CFG),
    .PMP_NUM_REGIONS (PMP_NUM_REGIONS)
  ) i_mpu (
    .clk                (clk),
    .rst_n              (rst_n),
    .core_trans_valid_i (core_trans_valid_i),
    .core_trans_ready_o (core_trans_ready_o),
    .core_addr_i        (core_addr_i),
    .core_we_i          (core_we_i),
    .core_wdata_i       (core_wdata_i),
    .core_misaligned_i  (core_misaligned_i),
    .core_resp_valid_o  (core_resp_valid_o),
    .core_rdata_o       (core_rdata_o),
    .core_status_o      (core_status_o),
    .bus_trans_valid_o  (bus_trans_valid_o),
    .bus_trans_ready_i  (bus_trans_ready_i),
    .bus_addr_o         (bus_addr_o),
    .bus_we_o           (bus_we_o),
    .bus_wdata_o        (bus_wdata_o),
    .bus_bufferable_o   (bus_bufferable_o),
    .bus_cacheable_o    (bus_cacheable_o),
    .bus_resp_valid_i   (bus_resp_valid_i),
    .bus_rdata_i        (bus_rdata_i),
    .pmp_top_i          (pmp_top_i),
    .pmp_r_i            (pmp_r_i),
    .pmp_w_i            (pmp_w_i),
    .pmp_l_i            (pmp_l_i),
    .priv_lvl_i         (priv_lvl_i),
    .one_txn_pend_i     (one_txn_pend),
    .core_mpu_err_o     (core_mpu_err_o)
  );

endmodule

/* src/mpu.sv */
/*
  Data-side memory protection unit
  Runs PMA and PMP checks, forwards passing requests, consumes failing ones
  and returns their fault response after older bus traffic has drained
*/
module mpu #(
  parameter int unsigned PMA_NUM_REGIONS = 1,
  parameter mpu_pkg::pma_region_t [PMA_NUM_REGIONS-1:0] PMA_CFG =
    {PMA_NUM_REGIONS{mpu_pkg::PMA_R_DEFAULT}},
  parameter int unsigned PMP_NUM_REGIONS = 4
) (
  input  logic                                                    clk,
  input  logic                                                    rst_n,
  // Core request
  input  logic                                                    core_trans_valid_i,
  output logic                                                    core_trans_ready_o,
  input  logic [mpu_pkg::ADDR_W-1:0]                              core_addr_i,
  input  logic                                                    core_we_i,
  input  logic [mpu_pkg::DATA_W-1:0]                              core_wdata_i,
  input  logic                                                    core_misaligned_i,
  // Core response
  output logic                                                    core_resp_valid_o,
  output logic [mpu_pkg::DATA_W-1:0]                              core_rdata_o,
  output mpu_pkg::mpu_status_e                                    core_status_o,
  // Bus request
  output logic                                                    bus_trans_valid_o,
  input  logic                                                    bus_trans_ready_i,
  output logic [mpu_pkg::ADDR_W-1:0]                              bus_addr_o,
  output logic                                                    bus_we_o,
  output logic [mpu_pkg::DATA_W-1:0]                              bus_wdata_o,
  output logic                                                    bus_bufferable_o,
  output logic                                                    bus_cacheable_o,
  // Bus response
  input  logic                                                    bus_resp_valid_i,
  input  logic [mpu_pkg::DATA_W-1:0]                              bus_rdata_i,
  // PMP configuration
  input  logic [mpu_pkg::MAX_PMP_REGIONS-1:0][mpu_pkg::ADDR_W-1:0] pmp_top_i,
  input  logic [mpu_pkg::MAX_PMP_REGIONS-1:0]                     pmp_r_i,
  input  logic [mpu_pkg::MAX_PMP_REGIONS-1:0]                     pmp_w_i,
  input  logic [mpu_pkg::MAX_PMP_REGIONS-1:0]                     pmp_l_i,
  input  mpu_pkg::priv_lvl_e                                      priv_lvl_i,
  // Tracker says one transaction left next cycle
  input  logic                                                    one_txn_pend_i,
  output logic                                                    core_mpu_err_o
);

  import mpu_pkg::*;

  logic        pma_err;
  logic        pmp_err;
  logic        mpu_err;
  logic        block_core;
  logic        block_bus;
  logic        err_ready;
  logic        err_valid;
  mpu_status_e err_status;
  pmp_acc_e    acc_type;
  mpu_state_e  state_q;
  mpu_state_e  state_n;

  ////////////////////////////////////////////////////////////////////////////
  // Checkers
  ////////////////////////////////////////////////////////////////////////////

  pma_check #(
    .PMA_NUM_REGIONS (PMA_NUM_REGIONS),
    .PMA_CFG         (PMA_CFG)
  ) i_pma_check (
    .addr_i       (core_addr_i),
    .misaligned_i (core_misaligned_i),
    .pma_err_o    (pma_err),
    .bufferable_o (bus_bufferable_o),
    .cacheable_o  (bus_cacheable_o)
  );

  assign acc_type = core_we_i ? PMP_ACC_WRITE : PMP_ACC_READ;

  pmp_check #(
    .PMP_NUM_REGIONS (PMP_NUM_REGIONS)
  ) i_pmp_check (
    .addr_i     (core_addr_i),
    .acc_i      (acc_type),
    .priv_lvl_i (priv_lvl_i),
    .pmp_top_i  (pmp_top_i),
    .pmp_r_i    (pmp_r_i),
    .pmp_w_i    (pmp_w_i),
    .pmp_l_i    (pmp_l_i),
    .pmp_err_o  (pmp_err)
  );

  assign mpu_err = pma_err || pmp_err;

  ////////////////////////////////////////////////////////////////////////////
  // Error-consuming FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_n    = state_q;
    block_core = 1'b0;
    block_bus  = 1'b0;
    err_ready  = 1'b0;
    err_valid  = 1'b0;
    err_status = MPU_OK;
    case (state_q)
      MPU_IDLE: begin
        if (core_trans_valid_i && mpu_err) begin
          // Swallow the request, nothing goes to the bus
          block_bus = 1'b1;
          err_ready = 1'b1;
          // Skip WAIT when this is the only transaction in flight
          if (core_we_i) begin
            state_n = one_txn_pend_i ? MPU_WR_ERR_RESP : MPU_WR_ERR_WAIT;
          end else begin
            state_n = one_txn_pend_i ? MPU_RE_ERR_RESP : MPU_RE_ERR_WAIT;
          end
        end
      end
      MPU_RE_ERR_WAIT, MPU_WR_ERR_WAIT: begin
        // Older bus transactions still draining
        block_bus  = 1'b1;
        block_core = 1'b1;
        if (one_txn_pend_i) begin
          state_n = (state_q == MPU_RE_ERR_WAIT) ? MPU_RE_ERR_RESP : MPU_WR_ERR_RESP;
        end
      end
      MPU_RE_ERR_RESP, MPU_WR_ERR_RESP: begin
        block_bus  = 1'b1;
        block_core = 1'b1;
        // Core always takes responses, one cycle is enough
        err_valid  = 1'b1;
        err_status = (state_q == MPU_RE_ERR_RESP) ? MPU_RE_FAULT : MPU_WR_FAULT;
        state_n    = MPU_IDLE;
      end
      default: begin
        state_n = MPU_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= MPU_IDLE;
    end else begin
      state_q <= state_n;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Request and response paths
  ////////////////////////////////////////////////////////////////////////////

  // Pass path has zero latency
  assign bus_trans_valid_o  = core_trans_valid_i && !block_bus;
  assign bus_addr_o         = core_addr_i;
  assign bus_we_o           = core_we_i;
  assign bus_wdata_o        = core_wdata_i;
  // Errored request accepted regardless of bus ready
  assign core_trans_ready_o = (bus_trans_ready_i && !block_core && !block_bus) || err_ready;

  // Bus and fault responses never overlap
  assign core_resp_valid_o = bus_resp_valid_i || err_valid;
  assign core_rdata_o      = bus_rdata_i;
  assign core_status_o     = err_status;

  assign core_mpu_err_o = mpu_err;

endmodule

/* src/txn_tracker.sv */
/*
  Outstanding transaction tracker
  Counts accepted, unanswered core transactions and flags one left next cycle
*/
module txn_tracker #(
  parameter int unsigned CNT_W = 3
) (
  input  logic clk,
  input  logic rst_n,
  input  logic accept_i,
  input  logic resp_i,
  output logic one_txn_pend_o
);

  logic [CNT_W-1:0] cnt_q;
  logic [CNT_W-1:0] cnt_n;

  // Acceptance adds one, response removes one
  // Both in one cycle leave the count unchanged
  assign cnt_n = cnt_q + CNT_W'(accept_i) - CNT_W'(resp_i);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_n;
    end
  end

  // Exactly one transaction pending in the next cycle
  assign one_txn_pend_o = (cnt_n == CNT_W'(1));

endmodule

/* src/pmp_check.sv */
/*
  PMP check
  Top-of-range region match with r/w permission, lock and privilege rules
*/
module pmp_check #(
  parameter int unsigned PMP_NUM_REGIONS = 4
) (
  input  logic [mpu_pkg::ADDR_W-1:0]                              addr_i,
  input  mpu_pkg::pmp_acc_e                                       acc_i,
  input  mpu_pkg::priv_lvl_e                                      priv_lvl_i,
  input  logic [mpu_pkg::MAX_PMP_REGIONS-1:0][mpu_pkg::ADDR_W-1:0] pmp_top_i,
  input  logic [mpu_pkg::MAX_PMP_REGIONS-1:0]                     pmp_r_i,
  input  logic [mpu_pkg::MAX_PMP_REGIONS-1:0]                     pmp_w_i,
  input  logic [mpu_pkg::MAX_PMP_REGIONS-1:0]                     pmp_l_i,
  output logic                                                    pmp_err_o
);

  import mpu_pkg::*;

  logic [ADDR_W-1:0] lo_addr;
  logic              match;
  logic              perm;
  logic              locked;

  ////////////////////////////////////////////////////////////////////////////
  // Region match
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    // First region starts at address zero
    lo_addr = '0;
    match   = 1'b0;
    perm    = 1'b0;
    locked  = 1'b0;
    for (int i = 0; i < PMP_NUM_REGIONS; i++) begin
      // Range is [top of previous, own top)
      if (!match && (addr_i >= lo_addr) && (addr_i < pmp_top_i[i])) begin
        match  = 1'b1;
        locked = pmp_l_i[i];
        perm   = (acc_i == PMP_ACC_WRITE) ? pmp_w_i[i] : pmp_r_i[i];
      end
      lo_addr = pmp_top_i[i];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Privilege rules
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    if (priv_lvl_i == PRIV_M) begin
      // M-mode only bound by locked regions
      pmp_err_o = match && locked && !perm;
    end else begin
      // U-mode needs a matching region with permission
      pmp_err_o = !match || !perm;
    end
  end

endmodule

/* src/pma_check.sv */
/*
  PMA check
  Looks up the fixed region table and returns error and memory attributes
*/
module pma_check #(
  parameter int unsigned PMA_NUM_REGIONS = 1,
  parameter mpu_pkg::pma_region_t [PMA_NUM_REGIONS-1:0] PMA_CFG =
    {PMA_NUM_REGIONS{mpu_pkg::PMA_R_DEFAULT}}
) (
  input  logic [mpu_pkg::ADDR_W-1:0] addr_i,
  input  logic                       misaligned_i,
  output logic                       pma_err_o,
  output logic                       bufferable_o,
  output logic                       cacheable_o
);

  import mpu_pkg::*;

  pma_region_t region;
  logic        found;

  // Priority lookup
  always_comb begin
    // Fallback when nothing matches
    region = PMA_R_DEFAULT;
    found  = 1'b0;
    for (int i = 0; i < PMA_NUM_REGIONS; i++) begin
      // Lowest index wins, later hits ignored
      if (!found && ((addr_i & PMA_CFG[i].size_mask) == PMA_CFG[i].base_addr)) begin
        region = PMA_CFG[i];
        found  = 1'b1;
      end
    end
  end

  // Misaligned access only allowed in main memory
  assign pma_err_o = misaligned_i && !region.main;

  // Attributes go straight to the bus request
  assign bufferable_o = region.bufferable;
  assign cacheable_o  = region.cacheable;

endmodule

/* src/mpu_pkg.sv */
/*
  MPU shared definitions
  Bus widths, FSM and status encodings, PMA region record
*/
package mpu_pkg;

  // Bus widths
  parameter int unsigned ADDR_W = 32;
  parameter int unsigned DATA_W = 32;

  // Upper bound for the packed PMP configuration ports
  parameter int unsigned MAX_PMP_REGIONS = 8;

  // Error-consuming FSM states
  typedef enum logic [2:0] {
    MPU_IDLE        = 3'd0,
    MPU_RE_ERR_WAIT = 3'd1,
    MPU_WR_ERR_WAIT = 3'd2,
    MPU_RE_ERR_RESP = 3'd3,
    MPU_WR_ERR_RESP = 3'd4
  } mpu_state_e;

  // Response status towards the core
  typedef enum logic [1:0] {
    MPU_OK       = 2'd0,
    MPU_RE_FAULT = 2'd1,
    MPU_WR_FAULT = 2'd2
  } mpu_status_e;

  // Privilege level, RISC-V encoding
  typedef enum logic [1:0] {
    PRIV_U = 2'b00,
    PRIV_M = 2'b11
  } priv_lvl_e;

  typedef enum logic {
    PMP_ACC_READ  = 1'b0,
    PMP_ACC_WRITE = 1'b1
  } pmp_acc_e;

  // One PMA region, 67 bits
  typedef struct packed {
    logic [ADDR_W-1:0] base_addr;
    logic [ADDR_W-1:0] size_mask;
    logic              main;
    logic              bufferable;
    logic              cacheable;
  } pma_region_t;

  // Attributes where no region matches
  parameter pma_region_t PMA_R_DEFAULT = '{
    base_addr:  '0,
    size_mask:  '0,
    main:       1'b1,
    bufferable: 1'b0,
    cacheable:  1'b0
  };

endpackage
